// ==== src.f ====
logic/timer_pkg.sv
logic/switch_conditioner.sv
logic/second_tick.sv
logic/countdown_fsm.sv
logic/digit_scanner.sv
logic/alarm_tone.sv
logic/kitchen_timer.sv
verif/kitchen_timer_tb.sv

// ==== verif/kitchen_timer_tb.sv ====
// Kitchen timer testbench
// Random button presses with bounce, display decoding and a reference model

`default_nettype none

module kitchen_timer_tb
  import timer_pkg::*;
();

  localparam int TICK_DIV        = 60;
  localparam int DEBOUNCE_CYCLES = 4;
  localparam int SCAN_DIV        = 2;
  localparam int TONE_DIV        = 3;

  // Bit positions of the buttons inside buttons_t
  localparam int BTN_START  = 0;
  localparam int BTN_CANCEL = 1;
  localparam int BTN_DN     = 2;
  localparam int BTN_UP     = 3;

  localparam logic [3:0] BLANK_CODE = 4'd10;

  logic       CLK;
  logic       rst;
  buttons_t   buttons;
  logic [7:0] SEG;
  logic [3:0] DIGIT;
  logic       BUZZER;

  integer     seed;
  int         cyc = 0;
  time_t      model_time;
  logic [3:0] model_stored;

  kitchen_timer #(
    .TICK_DIV        (TICK_DIV),
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
    .SCAN_DIV        (SCAN_DIV),
    .TONE_DIV        (TONE_DIV)
  ) dut_i (
    .CLK     (CLK),
    .rst     (rst),
    .buttons (buttons),
    .SEG     (SEG),
    .DIGIT   (DIGIT),
    .BUZZER  (BUZZER)
  );

  initial
  begin
    CLK = 1'b0;
  end

  always #20 CLK = ~CLK;

  always @(posedge CLK)
  begin
    cyc <= cyc + 1;
  end

  // ************************************************************
  // Error reporting and display decoding
  // ************************************************************

  task automatic report_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // Active-low segments in the order dp g f e d c b a
  // Code 15 marks a pattern that is no digit
  function automatic logic [3:0] decode_segments(input logic [7:0] seg);
    case (seg)
      8'hC0:   return 4'd0;
      8'hF9:   return 4'd1;
      8'hA4:   return 4'd2;
      8'hB0:   return 4'd3;
      8'h99:   return 4'd4;
      8'h92:   return 4'd5;
      8'h82:   return 4'd6;
      8'hF8:   return 4'd7;
      8'h80:   return 4'd8;
      8'h90:   return 4'd9;
      8'hFF:   return BLANK_CODE;
      default: return 4'd15;
    endcase
  endfunction

  function automatic time_t count_down(input time_t t);
    time_t r;
    r = t;
    if (t == '0)
      return r;
    if (t.secs != 4'd0)
      r.secs = t.secs - 4'd1;
    else
    begin
      r.secs = 4'd9;
      if (t.ten_secs != 4'd0)
        r.ten_secs = t.ten_secs - 4'd1;
      else
      begin
        r.ten_secs = 4'd5;
        r.mins     = t.mins - 4'd1;
      end
    end
    return r;
  endfunction

  function automatic int total_secs(input time_t t);
    return t.mins * 60 + t.ten_secs * 10 + t.secs;
  endfunction

  task automatic wait_digit(input logic [3:0] sel);
    int n;
    n = 0;
    @(negedge CLK);
    while (DIGIT !== sel)
    begin
      if (n >= 8 * SCAN_DIV)
        report_timeout("the next digit select on DIGIT");
      else
      begin
        n++;
        @(negedge CLK);
      end
    end
  endtask

  task automatic read_display(output time_t t, output bit blank_ok);
    wait_digit(4'b1110);
    t.secs = decode_segments(SEG);
    wait_digit(4'b1101);
    t.ten_secs = decode_segments(SEG);
    wait_digit(4'b1011);
    t.mins = decode_segments(SEG);
    wait_digit(4'b0111);
    blank_ok = (decode_segments(SEG) == BLANK_CODE);
  endtask

  // Two equal scans in a row give a consistent reading
  task automatic read_stable(output time_t t);
    time_t a;
    time_t b;
    bit    blank_a;
    bit    blank_b;
    int    tries;
    tries = 0;
    read_display(a, blank_a);
    read_display(b, blank_b);
    while (a !== b)
    begin
      if (tries >= 10)
        report_timeout("a stable display");
      else
      begin
        tries++;
        a = b;
        read_display(b, blank_b);
      end
    end
    assert (blank_a && blank_b)
    else
      report_error("leftmost digit is not blank");
    t = b;
  endtask

  task automatic check_time(input time_t got, input time_t exp, input string what);
    assert (got === exp)
    else
      report_error($sformatf("%s: display %0d:%0d%0d, expected %0d:%0d%0d", what,
        got.mins, got.ten_secs, got.secs, exp.mins, exp.ten_secs, exp.secs));
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles)
    begin
      @(negedge CLK);
      assert (BUZZER === 1'b0)
      else
        report_error("BUZZER is active while no alarm is expected");
    end
  endtask

  // ************************************************************
  // Stimulus and reference model
  // ************************************************************

  task automatic press_button(input int which, input bit bounce);
    buttons_t b;
    int       hold;
    int       gap;
    hold = DEBOUNCE_CYCLES + 6 + $unsigned($random(seed)) % (2 * DEBOUNCE_CYCLES - 5);
    gap  = 4 + $unsigned($random(seed)) % 8;
    b = '0;
    b[which] = 1'b1;
    if (bounce)
    begin
      @(negedge CLK);
      buttons = b;
      @(negedge CLK);
      buttons = '0;
      repeat (2) @(negedge CLK);
    end
    @(negedge CLK);
    buttons = b;
    repeat (hold) @(negedge CLK);
    buttons = '0;
    repeat (gap) @(negedge CLK);
  endtask

  task automatic glitch_button(input int which);
    buttons_t b;
    b = '0;
    b[which] = 1'b1;
    @(negedge CLK);
    buttons = b;
    @(negedge CLK);
    buttons = '0;
    repeat (DEBOUNCE_CYCLES + 6) @(negedge CLK);
  endtask

  task automatic model_setting_press(input int which);
    if (which == BTN_UP)
      model_time.mins = (model_time.mins >= 4'd9) ? 4'd1 : model_time.mins + 4'd1;
    else if (which == BTN_DN)
      model_time.mins = (model_time.mins <= 4'd1) ? 4'd9 : model_time.mins - 4'd1;
  endtask

  // Ticks since the start press may differ by one from cycles / TICK_DIV
  task automatic check_countdown(input time_t from, input int since, output time_t shown);
    time_t exp;
    int    c0;
    int    c1;
    int    lo;
    int    hi;
    bit    hit;
    c0 = cyc - since;
    read_stable(shown);
    c1 = cyc - since;
    lo = (c0 / TICK_DIV > 0) ? c0 / TICK_DIV - 1 : 0;
    hi = c1 / TICK_DIV + 1;
    exp = from;
    hit = 1'b0;
    for (int n = 0; n <= hi; n++)
    begin
      if (n >= lo && shown === exp)
        hit = 1'b1;
      exp = count_down(exp);
    end
    assert (hit)
    else
      report_error($sformatf("countdown shows %0d:%0d%0d, %0d to %0d ticks after %0d:%0d%0d",
        shown.mins, shown.ten_secs, shown.secs, lo, hi, from.mins, from.ten_secs, from.secs));
  endtask

  task automatic start_timer(output time_t from, output int since);
    model_stored = model_time.mins;
    from  = model_time;
    since = cyc;
    press_button(BTN_START, $unsigned($random(seed)) % 3 == 0);
  endtask

  initial
  begin
    time_t shown;
    time_t start_t;
    int    press_cyc;
    int    which;
    int    n;
    int    level;

    seed         = 32'hcda9_3aa6;
    rst          = 1'b1;
    buttons      = '0;
    model_time   = '{mins: 4'd1, ten_secs: 4'd0, secs: 4'd0};
    model_stored = 4'd1;
    repeat (10) @(negedge CLK);
    rst = 1'b0;

    read_stable(shown);
    check_time(shown, model_time, "after reset");
    expect_quiet(40);

    // Minute setting with up, dn, an ignored cancel and glitch-only presses
    for (int i = 0; i < 16; i++)
    begin
      which = BTN_CANCEL + $unsigned($random(seed)) % 3;
      if ($unsigned($random(seed)) % 4 == 0)
        glitch_button(which);
      else
      begin
        press_button(which, $unsigned($random(seed)) % 3 == 0);
        model_setting_press(which);
      end
      read_stable(shown);
      check_time(shown, model_time, "minute setting");
    end

    start_timer(start_t, press_cyc);
    repeat (2 * TICK_DIV + $unsigned($random(seed)) % TICK_DIV) @(negedge CLK);
    check_countdown(start_t, press_cyc, shown);
    repeat (TICK_DIV + $unsigned($random(seed)) % TICK_DIV) @(negedge CLK);
    check_countdown(start_t, press_cyc, shown);

    // Pause, hold still for three seconds, then resume and cancel
    press_button(BTN_START, 1'b1);
    check_countdown(start_t, press_cyc, shown);
    model_time = shown;
    repeat (3 * TICK_DIV) @(negedge CLK);
    read_stable(shown);
    check_time(shown, model_time, "paused display");
    start_timer(start_t, press_cyc);
    repeat (2 * TICK_DIV + $unsigned($random(seed)) % TICK_DIV) @(negedge CLK);
    check_countdown(start_t, press_cyc, shown);
    press_button(BTN_CANCEL, 1'b0);
    model_time = '{mins: model_stored, ten_secs: 4'd0, secs: 4'd0};
    read_stable(shown);
    check_time(shown, model_time, "cancel while running");

    // Run one full minute down to the alarm
    while (model_time.mins != 4'd1)
    begin
      press_button(BTN_UP, 1'b0);
      model_setting_press(BTN_UP);
    end
    read_stable(shown);
    check_time(shown, model_time, "one minute set");
    start_timer(start_t, press_cyc);
    n = 0;
    while (BUZZER !== 1'b1)
    begin
      if (n >= (total_secs(start_t) + 5) * TICK_DIV)
        report_timeout("the buzzer at the end of the countdown");
      else
      begin
        n++;
        @(negedge CLK);
      end
    end
    n = (cyc - press_cyc) / TICK_DIV - total_secs(start_t);
    assert (n >= -1 && n <= 1)
    else
      report_error($sformatf("alarm came %0d seconds off the set time", n));
    for (int k = 0; k < 4; k++)
    begin
      level = BUZZER;
      n = 0;
      while (BUZZER === level)
      begin
        if (n > 4 * TONE_DIV)
          report_timeout("the buzzer to toggle");
        else
        begin
          n++;
          @(negedge CLK);
        end
      end
      assert (n == TONE_DIV)
      else
        report_error($sformatf("buzzer half-period %0d cycles, expected %0d", n, TONE_DIV));
    end
    read_stable(shown);
    check_time(shown, '0, "alarm display");

    press_button(BTN_CANCEL, 1'b1);
    model_time = '{mins: model_stored, ten_secs: 4'd0, secs: 4'd0};
    expect_quiet(4 * TONE_DIV);
    read_stable(shown);
    check_time(shown, model_time, "cancel of the alarm");
    expect_quiet(40);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/kitchen_timer.sv ====
// Kitchen countdown timer top level
// Buttons in, multiplexed seven-segment display and buzzer out

`default_nettype none

module kitchen_timer
  import timer_pkg::*;
#(
  parameter int TICK_DIV        = 32000000,
  parameter int DEBOUNCE_CYCLES = 320000,
  parameter int SCAN_DIV        = 16000,
  parameter int TONE_DIV        = 16000
) (
  input  logic       CLK,
  input  logic       rst,
  input  buttons_t   buttons,
  output logic [7:0] SEG,
  output logic [3:0] DIGIT,
  output logic       BUZZER
);

  buttons_t presses;
  logic     running;
  logic     tick;
  logic     alarm_on;
  time_t    disp_time;

  switch_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) switch_conditioner_i (
    .CLK     (CLK),
    .rst     (rst),
    .buttons (buttons),
    .presses (presses)
  );

  second_tick #(.TICK_DIV(TICK_DIV)) second_tick_i (
    .CLK     (CLK),
    .rst     (rst),
    .running (running),
    .tick    (tick)
  );

  countdown_fsm countdown_fsm_i (
    .CLK       (CLK),
    .rst       (rst),
    .presses   (presses),
    .tick      (tick),
    .running   (running),
    .alarm_on  (alarm_on),
    .disp_time (disp_time)
  );

  digit_scanner #(.SCAN_DIV(SCAN_DIV)) digit_scanner_i (
    .CLK       (CLK),
    .rst       (rst),
    .disp_time (disp_time),
    .SEG       (SEG),
    .DIGIT     (DIGIT)
  );

  alarm_tone #(.TONE_DIV(TONE_DIV)) alarm_tone_i (
    .CLK      (CLK),
    .rst      (rst),
    .alarm_on (alarm_on),
    .BUZZER   (BUZZER)
  );

endmodule

`default_nettype wire

// ==== logic/alarm_tone.sv ====
// Buzzer tone generator
// Square wave with a half-period of TONE_DIV cycles while the alarm is on

`default_nettype none

module alarm_tone
  import timer_pkg::*;
#(
  parameter int TONE_DIV = 16000
) (
  input  logic CLK,
  input  logic rst,
  input  logic alarm_on,
  output logic BUZZER
);

  localparam int CW = (TONE_DIV > 1) ? $clog2(TONE_DIV) : 1;

  logic [CW-1:0] half_cnt;

  always_ff @(posedge CLK)
  begin
    if (rst || !alarm_on)
    begin
      half_cnt <= '0;
      BUZZER   <= 1'b0;
    end
    else if (half_cnt == CW'(TONE_DIV - 1))
    begin
      half_cnt <= '0;
      BUZZER   <= ~BUZZER;
    end
    else
    begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/digit_scanner.sv ====
// Seven-segment digit scanner
// Cycles through four digit positions and registers segments with the select

`default_nettype none

module digit_scanner
  import timer_pkg::*;
#(
  parameter int SCAN_DIV = 16000
) (
  input  logic       CLK,
  input  logic       rst,
  input  time_t      disp_time,
  output logic [7:0] SEG,
  output logic [3:0] DIGIT
);

  localparam int CW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  logic [CW-1:0] scan_cnt;
  logic [1:0]    digit_idx;
  logic [3:0]    cur_code;

  // Position 0 is the units digit, the leftmost position stays blank
  always_comb
  begin
    case (digit_idx)
      2'd0:    cur_code = disp_time.secs;
      2'd1:    cur_code = disp_time.ten_secs;
      2'd2:    cur_code = disp_time.mins;
      default: cur_code = BLANK_DIGIT;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      scan_cnt  <= '0;
      digit_idx <= 2'd0;
    end
    else if (scan_cnt == CW'(SCAN_DIV - 1))
    begin
      scan_cnt  <= '0;
      digit_idx <= digit_idx + 2'd1;
    end
    else
    begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  // SEG and DIGIT update on the same edge so the pattern always matches the select
  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      SEG   <= 8'hFF;
      DIGIT <= 4'b1110;
    end
    else
    begin
      SEG   <= seg_pattern(cur_code);
      DIGIT <= ~(4'b0001 << digit_idx);
    end
  end

  a_one_digit: assert property (@(posedge CLK) disable iff (rst)
    $onehot(~DIGIT));

endmodule

`default_nettype wire

// ==== logic/countdown_fsm.sv ====
// Countdown controller
// Minute setting, BCD countdown with pause and cancel, and alarm entry

`default_nettype none

module countdown_fsm
  import timer_pkg::*;
(
  input  logic     CLK,
  input  logic     rst,
  input  buttons_t presses,
  input  logic     tick,
  output logic     running,
  output logic     alarm_on,
  output time_t    disp_time
);

  timer_state_e state;
  logic [3:0]   mins_stored;
  logic         at_zero;

  assign running = (state == RUNNING);
  assign at_zero = (disp_time == '0);

  // ************************************************************
  // State, time digits and alarm level
  // ************************************************************

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      state       <= SETTING;
      alarm_on    <= 1'b0;
      mins_stored <= 4'd1;
      disp_time   <= '{mins: 4'd1, ten_secs: 4'd0, secs: 4'd0};
    end
    else
    begin
      case (state)
        SETTING:
        begin
          if (presses.start_stop)
          begin
            mins_stored <= disp_time.mins;
            state       <= RUNNING;
          end
          else if (presses.up)
          begin
            disp_time.mins <= (disp_time.mins >= 4'd9) ? 4'd1 : disp_time.mins + 4'd1;
          end
          else if (presses.dn)
          begin
            disp_time.mins <= (disp_time.mins <= 4'd1) ? 4'd9 : disp_time.mins - 4'd1;
          end
        end

        RUNNING:
        begin
          // Reaching 0:00 wins over any button in the same cycle
          if (at_zero)
          begin
            alarm_on <= 1'b1;
            state    <= BEEPING;
          end
          else if (presses.cancel)
          begin
            disp_time <= '{mins: mins_stored, ten_secs: 4'd0, secs: 4'd0};
            state     <= SETTING;
          end
          else if (presses.start_stop)
          begin
            state <= SETTING;
          end
          else if (tick)
          begin
            if (disp_time.secs == 4'd0)
            begin
              disp_time.secs <= 4'd9;
              if (disp_time.ten_secs == 4'd0)
              begin
                disp_time.ten_secs <= 4'd5;
                disp_time.mins     <= disp_time.mins - 4'd1;
              end
              else
              begin
                disp_time.ten_secs <= disp_time.ten_secs - 4'd1;
              end
            end
            else
            begin
              disp_time.secs <= disp_time.secs - 4'd1;
            end
          end
        end

        BEEPING:
        begin
          if (presses.cancel)
          begin
            alarm_on  <= 1'b0;
            disp_time <= '{mins: mins_stored, ten_secs: 4'd0, secs: 4'd0};
            state     <= SETTING;
          end
        end

        default:
        begin
          state <= SETTING;
        end
      endcase
    end
  end

  // ************************************************************
  // Checks
  // ************************************************************

  a_state_legal: assert property (@(posedge CLK) disable iff (rst)
    state inside {SETTING, RUNNING, BEEPING});

  a_alarm_in_beeping: assert property (@(posedge CLK) disable iff (rst)
    alarm_on == (state == BEEPING));

  a_bcd_range: assert property (@(posedge CLK) disable iff (rst)
    (disp_time.secs <= 4'd9) && (disp_time.ten_secs <= 4'd5));

endmodule

`default_nettype wire

// ==== logic/second_tick.sv ====
// Seconds prescaler
// Emits a one-cycle tick per TICK_DIV cycles and pauses with the timer

`default_nettype none

module second_tick
  import timer_pkg::*;
#(
  parameter int TICK_DIV = 32000000
) (
  input  logic CLK,
  input  logic rst,
  input  logic running,
  output logic tick
);

  localparam int CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [CW-1:0] div_cnt;
  logic          wrap;

  assign wrap = (div_cnt == CW'(TICK_DIV - 1));

  // Count holds its value while paused so a resume finishes the second
  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end
    else
    begin
      tick <= running & wrap;
      if (running)
        div_cnt <= wrap ? '0 : div_cnt + 1'b1;
    end
  end

  a_tick_only_running: assert property (@(posedge CLK) disable iff (rst)
    tick |-> $past(running));

endmodule

`default_nettype wire

// ==== logic/switch_conditioner.sv ====
// Switch conditioner for the four push buttons
// Synchronizes and debounces each button and emits a pulse per clean press

`default_nettype none

module switch_conditioner
  import timer_pkg::*;
#(
  parameter int DEBOUNCE_CYCLES = 320000
) (
  input  logic     CLK,
  input  logic     rst,
  input  buttons_t buttons,
  output buttons_t presses
);

  localparam int CW = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

  logic [3:0] raw_vec;
  logic [3:0] press_vec;

  assign raw_vec = buttons;
  assign presses = press_vec;

  for (genvar i = 0; i < 4; i++) begin : g_chan
    logic          sync_a;
    logic          sync_b;
    logic          level;
    logic          level_d;
    logic [CW-1:0] stable_cnt;

    // Two-flop synchronizer, the buttons are asynchronous to CLK
    always_ff @(posedge CLK)
    begin
      if (rst)
      begin
        sync_a <= 1'b0;
        sync_b <= 1'b0;
      end
      else
      begin
        sync_a <= raw_vec[i];
        sync_b <= sync_a;
      end
    end

    // The accepted level only follows after a full run of differing samples
    always_ff @(posedge CLK)
    begin
      if (rst)
      begin
        level      <= 1'b0;
        stable_cnt <= '0;
      end
      else if (sync_b == level)
      begin
        stable_cnt <= '0;
      end
      else if (stable_cnt == CW'(DEBOUNCE_CYCLES - 1))
      begin
        level      <= sync_b;
        stable_cnt <= '0;
      end
      else
      begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end

    always_ff @(posedge CLK)
    begin
      if (rst)
      begin
        level_d      <= 1'b0;
        press_vec[i] <= 1'b0;
      end
      else
      begin
        level_d      <= level;
        press_vec[i] <= level & ~level_d;
      end
    end

    a_single_pulse: assert property (@(posedge CLK) disable iff (rst)
      press_vec[i] |=> !press_vec[i]);
  end

endmodule

`default_nettype wire

// ==== logic/timer_pkg.sv ====
// Kitchen timer shared definitions
// Button and time structs, controller states and the seven-segment table

`default_nettype none

package timer_pkg;

  // One bit per push button, used for raw levels and for press pulses
  typedef struct packed {
    logic up;
    logic dn;
    logic cancel;
    logic start_stop;
  } buttons_t;

  // Displayed time as three BCD digits
  typedef struct packed {
    logic [3:0] mins;
    logic [3:0] ten_secs;
    logic [3:0] secs;
  } time_t;

  typedef enum logic [1:0] {
    SETTING = 2'd0,
    RUNNING = 2'd1,
    BEEPING = 2'd2
  } timer_state_e;

  localparam logic [3:0] BLANK_DIGIT = 4'd10;

  // Active-low segments, bit order dp g f e d c b a
  function automatic logic [7:0] seg_pattern(input logic [3:0] code);
    case (code)
      4'd0:    return 8'b1100_0000;
      4'd1:    return 8'b1111_1001;
      4'd2:    return 8'b1010_0100;
      4'd3:    return 8'b1011_0000;
      4'd4:    return 8'b1001_1001;
      4'd5:    return 8'b1001_0010;
      4'd6:    return 8'b1000_0010;
      4'd7:    return 8'b1111_1000;
      4'd8:    return 8'b1000_0000;
      4'd9:    return 8'b1001_0000;
      default: return 8'b1111_1111;
    endcase
  endfunction

endpackage

`default_nettype wire
